//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mips
FLAGS     ?= --binary --timing --assert
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- ex_stage.sv
`timescale 1ns/100ps

module ex_stage (
  input  logic                clk,
  input  logic                i_rst_n,
  input  logic                i_ex_valid,
  input  mips_pkg::reg_addr_t i_ex_rs,
  input  mips_pkg::reg_addr_t i_ex_rt,
  input  mips_pkg::word_t     i_ex_rs_data,
  input  mips_pkg::word_t     i_ex_rt_data,
  input  mips_pkg::word_t     i_ex_imm,
  input  mips_pkg::alu_op_e   i_ex_alu_op,
  input  logic                i_ex_alu_src,      // Immediate as operand B
  input  mips_pkg::reg_addr_t i_ex_dst,
  input  logic                i_ex_reg_write,
  input  logic                i_ex_mem_read,
  input  logic                i_ex_mem_write,
  input  logic                i_ex_halt,
  input  mips_pkg::fwd_sel_e  i_fwd_a,
  input  mips_pkg::fwd_sel_e  i_fwd_b,
  input  mips_pkg::word_t     i_wb_data,         // WB forward source
  output logic                o_mem_valid,       // EX/MEM register
  output mips_pkg::word_t     o_mem_alu_result,
  output mips_pkg::word_t     o_mem_store_data,
  output mips_pkg::reg_addr_t o_mem_dst,
  output logic                o_mem_reg_write,
  output logic                o_mem_read,
  output logic                o_mem_write,
  output logic                o_mem_halt
);

  mips_pkg::word_t opnd_a, rt_fwd, opnd_b, alu_result;

  function automatic mips_pkg::word_t fwd_mux(input mips_pkg::fwd_sel_e sel,
                                              input mips_pkg::word_t    id_val);
    case (sel)
      mips_pkg::FWD_MEM: return o_mem_alu_result;
      mips_pkg::FWD_WB:  return i_wb_data;
      default:           return id_val;
    endcase
  endfunction

  always_comb begin
    opnd_a = fwd_mux(i_fwd_a, i_ex_rs_data);
    rt_fwd = fwd_mux(i_fwd_b, i_ex_rt_data);          // Also the store data
    opnd_b = i_ex_alu_src ? i_ex_imm : rt_fwd;
    case (i_ex_alu_op)
      mips_pkg::ALU_SUB: alu_result = opnd_a - opnd_b;
      mips_pkg::ALU_AND: alu_result = opnd_a & opnd_b;
      mips_pkg::ALU_OR:  alu_result = opnd_a | opnd_b;
      mips_pkg::ALU_XOR: alu_result = opnd_a ^ opnd_b;
      mips_pkg::ALU_SLT: alu_result = {31'b0, $signed(opnd_a) < $signed(opnd_b)};
      default:           alu_result = opnd_a + opnd_b;  // ADDU, ADDIU, address
    endcase
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_mem_valid <= 1'b0;
    end else begin
      o_mem_valid <= i_ex_valid;
    end
  end

  // EX/MEM payload
  always_ff @(posedge clk) begin
    o_mem_alu_result <= alu_result;
    o_mem_store_data <= rt_fwd;
    o_mem_dst        <= i_ex_dst;
    o_mem_reg_write  <= i_ex_reg_write;
    o_mem_read       <= i_ex_mem_read;
    o_mem_write      <= i_ex_mem_write;
    o_mem_halt       <= i_ex_halt;
  end

endmodule

//--- forwarding_unit.sv
`timescale 1ns/100ps

module forwarding_unit (
  input  mips_pkg::reg_addr_t i_ex_rs,
  input  mips_pkg::reg_addr_t i_ex_rt,
  input  logic                i_mem_valid,      // EX/MEM slot
  input  logic                i_mem_reg_write,
  input  mips_pkg::reg_addr_t i_mem_dst,
  input  logic                i_wb_we,          // MEM/WB write, never r0
  input  mips_pkg::reg_addr_t i_wb_reg,
  output mips_pkg::fwd_sel_e  o_fwd_a,
  output mips_pkg::fwd_sel_e  o_fwd_b
);

  logic mem_ok;  // EX/MEM holds a usable result

  assign mem_ok = i_mem_valid && i_mem_reg_write && (i_mem_dst != '0);

  // Newest producer wins
  function automatic mips_pkg::fwd_sel_e pick(input mips_pkg::reg_addr_t src);
    if (mem_ok && (i_mem_dst == src)) begin
      return mips_pkg::FWD_MEM;
    end else if (i_wb_we && (i_wb_reg == src)) begin
      return mips_pkg::FWD_WB;
    end
    return mips_pkg::FWD_NONE;
  endfunction

  always_comb begin
    o_fwd_a = pick(i_ex_rs);
    o_fwd_b = pick(i_ex_rt);
  end

endmodule

//--- id_stage.sv
`timescale 1ns/100ps

module id_stage (
  input  logic                clk,
  input  logic                i_rst_n,
  input  logic                i_if_valid,
  input  mips_pkg::word_t     i_if_instr,
  input  logic                i_wb_we,         // Register file write port
  input  mips_pkg::reg_addr_t i_wb_reg,
  input  mips_pkg::word_t     i_wb_data,
  output logic                o_stall,         // Load-use hazard
  output logic                o_halt_seen,
  output logic                o_ex_valid,      // ID/EX register
  output mips_pkg::reg_addr_t o_ex_rs,
  output mips_pkg::reg_addr_t o_ex_rt,
  output mips_pkg::word_t     o_ex_rs_data,
  output mips_pkg::word_t     o_ex_rt_data,
  output mips_pkg::word_t     o_ex_imm,
  output mips_pkg::alu_op_e   o_ex_alu_op,
  output logic                o_ex_alu_src,
  output mips_pkg::reg_addr_t o_ex_dst,
  output logic                o_ex_reg_write,
  output logic                o_ex_mem_read,
  output logic                o_ex_mem_write,
  output logic                o_ex_halt
);

  mips_pkg::opcode_t   opcode;
  mips_pkg::funct_t    funct;
  mips_pkg::reg_addr_t rs, rt, rd, dst;
  mips_pkg::word_t     rs_data, rt_data, imm;
  mips_pkg::alu_op_e   alu_op;
  logic                alu_src, reg_write, mem_read, mem_write;
  logic                rs_used, rt_used;   // Operands really read
  logic                is_halt;
  logic                halt_q;             // HALT already decoded
  logic                load_use;

  // Instruction fields
  assign opcode  = i_if_instr[31:26];
  assign rs      = i_if_instr[25:21];
  assign rt      = i_if_instr[20:16];
  assign rd      = i_if_instr[15:11];
  assign funct   = i_if_instr[5:0];
  assign imm     = {{16{i_if_instr[15]}}, i_if_instr[15:0]};  // Sign extension
  assign is_halt = (i_if_instr == mips_pkg::INSTR_HALT);

  reg_file reg_file_inst (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_rs      (rs),
    .i_rt      (rt),
    .i_we      (i_wb_we),
    .i_wr_reg  (i_wb_reg),
    .i_wr_data (i_wb_data),
    .o_rs_data (rs_data),
    .o_rt_data (rt_data)
  );

  always_comb begin
    alu_op    = mips_pkg::ALU_ADD;
    alu_src   = 1'b0;
    dst       = rt;                 // Immediate forms write rt
    reg_write = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    rs_used   = 1'b0;
    rt_used   = 1'b0;
    case (opcode)
      mips_pkg::OP_RTYPE: begin
        dst       = rd;
        rs_used   = 1'b1;
        rt_used   = 1'b1;
        reg_write = 1'b1;
        case (funct)
          mips_pkg::FN_ADDU: alu_op = mips_pkg::ALU_ADD;
          mips_pkg::FN_SUBU: alu_op = mips_pkg::ALU_SUB;
          mips_pkg::FN_AND:  alu_op = mips_pkg::ALU_AND;
          mips_pkg::FN_OR:   alu_op = mips_pkg::ALU_OR;
          mips_pkg::FN_XOR:  alu_op = mips_pkg::ALU_XOR;
          mips_pkg::FN_SLT:  alu_op = mips_pkg::ALU_SLT;
          default:           reg_write = 1'b0;  // Unknown function is a no-op
        endcase
      end
      mips_pkg::OP_ADDIU: begin
        alu_src   = 1'b1;
        rs_used   = 1'b1;
        reg_write = 1'b1;
      end
      mips_pkg::OP_LW: begin
        alu_src   = 1'b1;
        rs_used   = 1'b1;
        reg_write = 1'b1;
        mem_read  = 1'b1;
      end
      mips_pkg::OP_SW: begin
        alu_src   = 1'b1;
        rs_used   = 1'b1;
        rt_used   = 1'b1;                       // Store data
        mem_write = 1'b1;
      end
      default: begin
        alu_src   = 1'b0;                       // HALT and unknown opcodes
      end
    endcase
  end

  // Load in ID/EX feeding an operand of this instruction
  assign load_use = o_ex_valid && o_ex_mem_read &&
                    ((rs_used && (o_ex_dst == rs)) || (rt_used && (o_ex_dst == rt)));
  assign o_stall     = i_if_valid && load_use;
  assign o_halt_seen = halt_q || (i_if_valid && is_halt);  // Takes effect in the decode cycle

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_ex_valid <= 1'b0;
      halt_q     <= 1'b0;
    end else begin
      o_ex_valid <= i_if_valid && !o_stall;  // Bubble on stall
      halt_q     <= o_halt_seen;
    end
  end

  // ID/EX payload, qualified by o_ex_valid
  always_ff @(posedge clk) begin
    o_ex_rs        <= rs;
    o_ex_rt        <= rt;
    o_ex_rs_data   <= rs_data;
    o_ex_rt_data   <= rt_data;
    o_ex_imm       <= imm;
    o_ex_alu_op    <= alu_op;
    o_ex_alu_src   <= alu_src;
    o_ex_dst       <= dst;
    o_ex_reg_write <= reg_write;
    o_ex_mem_read  <= mem_read;
    o_ex_mem_write <= mem_write;
    o_ex_halt      <= is_halt;
  end

endmodule

//--- if_stage.sv
`timescale 1ns/100ps

module if_stage (
  input  logic                 clk,
  input  logic                 i_rst_n,
  input  logic                 i_stall,       // Load-use hold from decode
  input  logic                 i_halt_seen,   // HALT decoded now or earlier
  input  logic                 i_imem_we,
  input  mips_pkg::imem_addr_t i_imem_addr,
  input  mips_pkg::word_t      i_imem_wdata,
  output logic                 o_if_valid,
  output mips_pkg::word_t      o_if_instr
);

  mips_pkg::word_t      imem [mips_pkg::IMEM_DEPTH];  // Program storage
  mips_pkg::imem_addr_t pc;                           // Word index of the next fetch

  // Program load port
  always_ff @(posedge clk) begin
    if (i_imem_we) begin
      imem[i_imem_addr] <= i_imem_wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      pc         <= '0;
      o_if_valid <= 1'b0;
    end else if (i_halt_seen) begin
      o_if_valid <= 1'b0;        // PC frozen and decode starved after HALT
    end else if (!i_stall) begin
      pc         <= pc + 1'b1;   // One word per cycle
      o_if_valid <= 1'b1;
    end
  end

  // IF/ID instruction word
  always_ff @(posedge clk) begin
    if (!i_halt_seen && !i_stall) begin
      o_if_instr <= imem[pc];    // Combinational read registered here
    end
  end

endmodule

//--- mem_stage.sv
`timescale 1ns/100ps

module mem_stage (
  input  logic                clk,
  input  logic                i_rst_n,
  input  logic                i_mem_valid,
  input  mips_pkg::word_t     i_mem_alu_result,  // Byte address for loads and stores
  input  mips_pkg::word_t     i_mem_store_data,
  input  mips_pkg::reg_addr_t i_mem_dst,
  input  logic                i_mem_reg_write,
  input  logic                i_mem_read,
  input  logic                i_mem_write,
  input  logic                i_mem_halt,
  output logic                o_wb_we,           // MEM/WB register
  output mips_pkg::reg_addr_t o_wb_reg,
  output mips_pkg::word_t     o_wb_data,
  output logic                o_halt
);

  mips_pkg::word_t      dmem [mips_pkg::DMEM_DEPTH];
  mips_pkg::dmem_addr_t dmem_addr;
  mips_pkg::word_t      load_data;

  assign dmem_addr = i_mem_alu_result[7:2];  // Word index
  assign load_data = dmem[dmem_addr];        // Asynchronous read

  always_ff @(posedge clk) begin
    if (i_mem_valid && i_mem_write) begin
      dmem[dmem_addr] <= i_mem_store_data;   // Store on exit from MEM
    end
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_wb_we <= 1'b0;
      o_halt  <= 1'b0;
    end else begin
      o_wb_we <= i_mem_valid && i_mem_reg_write && (i_mem_dst != '0);
      o_halt  <= o_halt || (i_mem_valid && i_mem_halt);  // Sticky until reset
    end
  end

  // MEM/WB payload
  always_ff @(posedge clk) begin
    o_wb_reg  <= i_mem_dst;
    o_wb_data <= i_mem_read ? load_data : i_mem_alu_result;
  end

endmodule

//--- mips_pkg.sv
package mips_pkg;

  // Memory sizes in words
  localparam int IMEM_DEPTH = 64;
  localparam int DMEM_DEPTH = 64;

  typedef logic [31:0]                     word_t;       // Data or instruction word
  typedef logic [4:0]                      reg_addr_t;   // Register number
  typedef logic [$clog2(IMEM_DEPTH)-1:0]   imem_addr_t;  // Instruction memory word index
  typedef logic [$clog2(DMEM_DEPTH)-1:0]   dmem_addr_t;  // Data memory word index
  typedef logic [5:0]                      opcode_t;     // Major opcode field
  typedef logic [5:0]                      funct_t;      // R-type function field

  // Major opcodes
  localparam opcode_t OP_RTYPE = 6'h00;
  localparam opcode_t OP_ADDIU = 6'h09;
  localparam opcode_t OP_LW    = 6'h23;
  localparam opcode_t OP_SW    = 6'h2b;

  localparam word_t INSTR_HALT = 32'hffff_ffff;  // All-ones word stops the core

  // R-type function codes
  localparam funct_t FN_ADDU = 6'h21;
  localparam funct_t FN_SUBU = 6'h23;
  localparam funct_t FN_AND  = 6'h24;
  localparam funct_t FN_OR   = 6'h25;
  localparam funct_t FN_XOR  = 6'h26;
  localparam funct_t FN_SLT  = 6'h2a;

  typedef enum logic [2:0] {
    ALU_ADD,  // Wraparound add, also address generation
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT   // Signed compare
  } alu_op_e;

  typedef enum logic [1:0] {
    FWD_NONE,  // Value read in decode
    FWD_MEM,   // EX/MEM result
    FWD_WB     // MEM/WB write data
  } fwd_sel_e;

endpackage

//--- mips_stimulus.txt
# Program: word count (decimal), then one instruction word (hex) per line
# Expected: write count (decimal), then one line per write: register (decimal) value (hex)
28
24010005
2402fffd
00221821
00612023
0081282a
0024302a
24070f0f
240800ff
00e84824
00e85025
00e85826
24200007
00016021
ac040008
ac0b000c
8c0d0008
01a17021
8c0f000c
002f8026
2611fff0
00119023
0240982a
ac130010
8c140010
0294a821
ffffffff
24160001
24170002
21
1 00000005
2 fffffffd
3 00000002
4 fffffffd
5 00000001
6 00000000
7 00000f0f
8 000000ff
9 0000000f
10 00000fff
11 00000ff0
12 00000005
13 fffffffd
14 00000002
15 00000ff0
16 00000ff5
17 00000fe5
18 fffff01b
19 00000001
20 00000001
21 00000002

//--- mips_top.sv
`timescale 1ns/100ps

module mips_top (
  input  logic                 clk,
  input  logic                 i_rst_n,
  input  logic                 i_imem_we,      // Program load, only while in reset
  input  mips_pkg::imem_addr_t i_imem_addr,
  input  mips_pkg::word_t      i_imem_wdata,
  output logic                 o_wb_valid,     // One pulse per retired write
  output mips_pkg::reg_addr_t  o_wb_reg,
  output mips_pkg::word_t      o_wb_data,
  output logic                 o_halt
);

  // IF/ID
  logic                if_valid;
  mips_pkg::word_t     if_instr;
  logic                stall, halt_seen;

  // ID/EX
  logic                ex_valid, ex_alu_src, ex_reg_write, ex_mem_read, ex_mem_write, ex_halt;
  mips_pkg::reg_addr_t ex_rs, ex_rt, ex_dst;
  mips_pkg::word_t     ex_rs_data, ex_rt_data, ex_imm;
  mips_pkg::alu_op_e   ex_alu_op;
  mips_pkg::fwd_sel_e  fwd_a, fwd_b;

  // EX/MEM
  logic                mem_valid, mem_reg_write, mem_read, mem_write, mem_halt;
  mips_pkg::word_t     mem_alu_result, mem_store_data;
  mips_pkg::reg_addr_t mem_dst;

  if_stage if_stage_inst (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_stall      (stall),
    .i_halt_seen  (halt_seen),
    .i_imem_we    (i_imem_we),
    .i_imem_addr  (i_imem_addr),
    .i_imem_wdata (i_imem_wdata),
    .o_if_valid   (if_valid),
    .o_if_instr   (if_instr)
  );

  id_stage id_stage_inst (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_if_valid     (if_valid),
    .i_if_instr     (if_instr),
    .i_wb_we        (o_wb_valid),     // Writeback closes the loop here
    .i_wb_reg       (o_wb_reg),
    .i_wb_data      (o_wb_data),
    .o_stall        (stall),
    .o_halt_seen    (halt_seen),
    .o_ex_valid     (ex_valid),
    .o_ex_rs        (ex_rs),
    .o_ex_rt        (ex_rt),
    .o_ex_rs_data   (ex_rs_data),
    .o_ex_rt_data   (ex_rt_data),
    .o_ex_imm       (ex_imm),
    .o_ex_alu_op    (ex_alu_op),
    .o_ex_alu_src   (ex_alu_src),
    .o_ex_dst       (ex_dst),
    .o_ex_reg_write (ex_reg_write),
    .o_ex_mem_read  (ex_mem_read),
    .o_ex_mem_write (ex_mem_write),
    .o_ex_halt      (ex_halt)
  );

  forwarding_unit forwarding_unit_inst (
    .i_ex_rs         (ex_rs),
    .i_ex_rt         (ex_rt),
    .i_mem_valid     (mem_valid),
    .i_mem_reg_write (mem_reg_write),
    .i_mem_dst       (mem_dst),
    .i_wb_we         (o_wb_valid),
    .i_wb_reg        (o_wb_reg),
    .o_fwd_a         (fwd_a),
    .o_fwd_b         (fwd_b)
  );

  ex_stage ex_stage_inst (
    .clk              (clk),
    .i_rst_n          (i_rst_n),
    .i_ex_valid       (ex_valid),
    .i_ex_rs          (ex_rs),
    .i_ex_rt          (ex_rt),
    .i_ex_rs_data     (ex_rs_data),
    .i_ex_rt_data     (ex_rt_data),
    .i_ex_imm         (ex_imm),
    .i_ex_alu_op      (ex_alu_op),
    .i_ex_alu_src     (ex_alu_src),
    .i_ex_dst         (ex_dst),
    .i_ex_reg_write   (ex_reg_write),
    .i_ex_mem_read    (ex_mem_read),
    .i_ex_mem_write   (ex_mem_write),
    .i_ex_halt        (ex_halt),
    .i_fwd_a          (fwd_a),
    .i_fwd_b          (fwd_b),
    .i_wb_data        (o_wb_data),
    .o_mem_valid      (mem_valid),
    .o_mem_alu_result (mem_alu_result),
    .o_mem_store_data (mem_store_data),
    .o_mem_dst        (mem_dst),
    .o_mem_reg_write  (mem_reg_write),
    .o_mem_read       (mem_read),
    .o_mem_write      (mem_write),
    .o_mem_halt       (mem_halt)
  );

  mem_stage mem_stage_inst (
    .clk              (clk),
    .i_rst_n          (i_rst_n),
    .i_mem_valid      (mem_valid),
    .i_mem_alu_result (mem_alu_result),
    .i_mem_store_data (mem_store_data),
    .i_mem_dst        (mem_dst),
    .i_mem_reg_write  (mem_reg_write),
    .i_mem_read       (mem_read),
    .i_mem_write      (mem_write),
    .i_mem_halt       (mem_halt),
    .o_wb_we          (o_wb_valid),   // MEM/WB drives the retirement report
    .o_wb_reg         (o_wb_reg),
    .o_wb_data        (o_wb_data),
    .o_halt           (o_halt)
  );

endmodule

//--- reg_file.sv
`timescale 1ns/100ps

module reg_file (
  input  logic                clk,
  input  logic                i_rst_n,
  input  mips_pkg::reg_addr_t i_rs,
  input  mips_pkg::reg_addr_t i_rt,
  input  logic                i_we,
  input  mips_pkg::reg_addr_t i_wr_reg,
  input  mips_pkg::word_t     i_wr_data,
  output mips_pkg::word_t     o_rs_data,
  output mips_pkg::word_t     o_rt_data
);

  mips_pkg::word_t regs [32];
  logic            wr_ok;      // Write that actually lands

  assign wr_ok = i_we && (i_wr_reg != '0);  // r0 stays zero

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_ok) begin
      regs[i_wr_reg] <= i_wr_data;
    end
  end

  // Same-cycle write returns the new value
  assign o_rs_data = (wr_ok && (i_wr_reg == i_rs)) ? i_wr_data : regs[i_rs];
  assign o_rt_data = (wr_ok && (i_wr_reg == i_rt)) ? i_wr_data : regs[i_rt];

endmodule

//--- tb.f
mips_pkg.sv
if_stage.sv
reg_file.sv
id_stage.sv
forwarding_unit.sv
ex_stage.sv
mem_stage.sv
mips_top.sv
tb_mips.sv

//--- tb_mips.sv
`timescale 1ns/100ps

module tb_mips;

  localparam int MAX_WORDS  = mips_pkg::IMEM_DEPTH;  // Program cannot exceed imem
  localparam int MAX_WRITES = 64;

  logic                 clk;
  logic                 i_rst_n;
  logic                 i_imem_we;
  mips_pkg::imem_addr_t i_imem_addr;
  mips_pkg::word_t      i_imem_wdata;
  logic                 o_wb_valid;
  mips_pkg::reg_addr_t  o_wb_reg;
  mips_pkg::word_t      o_wb_data;
  logic                 o_halt;

  mips_pkg::word_t     prog     [MAX_WORDS];   // Program image from the file
  mips_pkg::reg_addr_t exp_reg  [MAX_WRITES];  // Expected writes in program order
  mips_pkg::word_t     exp_data [MAX_WRITES];
  int                  n_words;
  int                  n_writes;
  int                  seen;                   // Retired writes checked so far
  int                  timeout_cycles;
  logic                loaded;                 // Watchdog waits for the parsed stimulus

  mips_top mips_top_inst (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_imem_we    (i_imem_we),
    .i_imem_addr  (i_imem_addr),
    .i_imem_wdata (i_imem_wdata),
    .o_wb_valid   (o_wb_valid),
    .o_wb_reg     (o_wb_reg),
    .o_wb_data    (o_wb_data),
    .o_halt       (o_halt)
  );

  always #20 clk = ~clk;  // 40 ns period

  task automatic abort_run;
    $display("TB FAILED");
    $fatal(1);
  endtask

  // Fetches the next line that holds data and skips comments and blank lines
  task automatic read_data_line(input int fd, output string line);
    string text;
    int    rc;
    line = "";
    while (line == "" && !$feof(fd)) begin
      rc = $fgets(text, fd);
      if (rc > 0 && text.getc(0) != "#" && text.getc(0) != "\n") begin
        line = text;
      end
    end
    if (line == "") begin
      $display("Stimulus file ended before all entries were read");
      abort_run();
    end
  endtask

  task automatic load_stimulus;
    int              fd;
    string           line;
    int              reg_num;
    mips_pkg::word_t value;
    fd = $fopen("mips_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Cannot open mips_stimulus.txt for reading");
      abort_run();
    end
    read_data_line(fd, line);
    void'($sscanf(line, "%d", n_words));
    if (n_words < 1 || n_words > MAX_WORDS) begin
      $display("Program word count %0d does not fit instruction memory", n_words);
      abort_run();
    end
    for (int i = 0; i < n_words; i++) begin
      read_data_line(fd, line);
      void'($sscanf(line, "%h", value));
      prog[i] = value;
    end
    read_data_line(fd, line);
    void'($sscanf(line, "%d", n_writes));
    if (n_writes < 0 || n_writes > MAX_WRITES) begin
      $display("Expected write count %0d is out of range", n_writes);
      abort_run();
    end
    for (int i = 0; i < n_writes; i++) begin
      read_data_line(fd, line);
      void'($sscanf(line, "%d %h", reg_num, value));
      exp_reg[i]  = mips_pkg::reg_addr_t'(reg_num);
      exp_data[i] = value;
    end
    $fclose(fd);
  endtask

  // Retirement checker samples mid-cycle where outputs are stable
  always @(negedge clk) begin
    if (i_rst_n && o_wb_valid) begin
      assert (seen < n_writes) else begin
        $display("Retired write at %0d ns after all %0d expected writes", $time, n_writes);
        abort_run();
      end
      assert (o_wb_reg == exp_reg[seen]) else begin
        $display("FAIL %0d ns: o_wb_reg = %0d, expected %0d (write %0d)",
                 $time, o_wb_reg, exp_reg[seen], seen);
        abort_run();
      end
      assert (o_wb_data == exp_data[seen]) else begin
        $display("FAIL %0d ns: o_wb_data = %h, expected %h (write %0d)",
                 $time, o_wb_data, exp_data[seen], seen);
        abort_run();
      end
      seen <= seen + 1;  // Seen by other processes after this edge
    end
  end

  initial begin
    clk          = 1'b0;
    i_rst_n      = 1'b0;
    i_imem_we    = 1'b0;
    i_imem_addr  = '0;
    i_imem_wdata = '0;
    seen         = 0;
    loaded       = 1'b0;
    load_stimulus();
    timeout_cycles = 40 + 8 * n_words;
    loaded         = 1'b1;
    for (int i = 0; i < n_words; i++) begin  // Program load while the core is held in reset
      @(negedge clk);
      i_imem_we    = 1'b1;
      i_imem_addr  = mips_pkg::imem_addr_t'(i);
      i_imem_wdata = prog[i];
    end
    @(negedge clk);
    i_imem_we = 1'b0;
    repeat (2) @(negedge clk);               // At least two reset cycles without loading
    i_rst_n = 1'b1;
    while (o_halt !== 1'b1) begin
      @(negedge clk);
    end
    assert (seen == n_writes) else begin
      $display("Halt reported after %0d of %0d expected writes", seen, n_writes);
      abort_run();
    end
    repeat (5) begin                         // Nothing past HALT may retire
      @(negedge clk);
      assert (o_wb_valid === 1'b0) else begin
        $display("FAIL %0d ns: o_wb_valid = %b, expected 0", $time, o_wb_valid);
        abort_run();
      end
      assert (o_halt === 1'b1) else begin
        $display("FAIL %0d ns: o_halt = %b, expected 1", $time, o_halt);
        abort_run();
      end
    end
    $display("TB PASSED");
    $finish;
  end

  // Watchdog sized from the program length
  initial begin
    wait (loaded === 1'b1);
    repeat (timeout_cycles) @(posedge clk);
    $display("Timeout: the core never halted within %0d cycles", timeout_cycles);
    abort_run();
  end

endmodule
